// ==== rtl/pc_types_pkg.sv ====
`default_nettype none

// widths shared by the program counter datapath
package pc_types_pkg;

  // one data byte, also one half of an address
  typedef logic [7:0] pc_byte_t;

  // full program counter value
  typedef logic [15:0] pc_addr_t;  // hi byte in [15:8], lo byte in [7:0]

  // lo byte value that ripples a carry into the hi byte
  localparam pc_byte_t PC_BYTE_TC = 8'hff;

endpackage : pc_types_pkg

`default_nettype wire

// ==== rtl/pc_ctrl_pkg.sv ====
`default_nettype none

// sequencer command set and control defaults
package pc_ctrl_pkg;

  // step commands from the microcode sequencer
  typedef enum logic [2:0] {
    op_hold       = 3'd0,  // nothing changes
    op_count      = 3'd1,  // pc + 1
    op_load_hitmp = 3'd2,  // latch hi holding byte, pc still counts
    op_load_lo    = 3'd3,  // replace lo byte only
    op_jump       = 3'd4   // lo from data, hi from holding byte
  } pc_op_t;
  // codes 5..7 are unused and behave as op_hold

  // fetch address queue depth unless the top level overrides it
  localparam int unsigned FETCH_DEPTH_DEFAULT = 2;

endpackage : pc_ctrl_pkg

`default_nettype wire

// ==== rtl/pc_step_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one decoded step command, intake register to pc core
interface pc_step_if;
  import pc_types_pkg::*;

  logic     step_valid;  // intake holds a command
  logic     step_ready;  // core can apply it this cycle
  logic     count_en;    // lo counts, hi counts on lo terminal count
  logic     load_lo;     // lo loads from step_data
  logic     load_hi;     // hi loads from the holding byte
  logic     hitmp_en;    // holding byte loads from step_data
  pc_byte_t step_data;

  modport intake (
    output step_valid, count_en, load_lo, load_hi, hitmp_en, step_data,
    input  step_ready
  );

  modport core (
    input  step_valid, count_en, load_lo, load_hi, hitmp_en, step_data,
    output step_ready
  );

endinterface : pc_step_if

`default_nettype wire

// ==== rtl/pc_cmd_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

// single slot command register with op decode
module pc_cmd_intake (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         cmd_valid,
  output logic                        cmd_ready,
  input  wire pc_ctrl_pkg::pc_op_t    cmd_op,
  input  wire pc_types_pkg::pc_byte_t cmd_data,
  pc_step_if.intake                   step
);
  import pc_types_pkg::*;
  import pc_ctrl_pkg::*;

  logic     held_q;     // slot occupied
  logic     count_q;
  logic     lo_q;
  logic     hi_q;
  logic     hitmp_q;
  pc_byte_t data_q;
  logic     dec_count;
  logic     dec_lo;
  logic     dec_hi;
  logic     dec_hitmp;
  logic     take;       // command accepted this edge

  // op to enables, same split as the discrete PE/CEP/EN strobes
  always_comb
  begin
    dec_count = 1'b0;
    dec_lo    = 1'b0;
    dec_hi    = 1'b0;
    dec_hitmp = 1'b0;
    case (cmd_op)
      op_count:      dec_count = 1'b1;
      op_load_hitmp:
      begin
        dec_count = 1'b1;  // not a lo load, so the pc still advances
        dec_hitmp = 1'b1;
      end
      op_load_lo:    dec_lo = 1'b1;
      op_jump:
      begin
        dec_lo = 1'b1;
        dec_hi = 1'b1;     // hi comes from the holding byte
      end
      default:       dec_count = 1'b0;  // hold and unused codes
    endcase
  end

  // free slot, or slot drains into the core this same edge
  assign cmd_ready = !held_q || step.step_ready;
  assign take      = cmd_valid && cmd_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
      held_q <= 1'b0;
    else if (take)
      held_q <= 1'b1;  // refill wins over drain
    else if (step.step_ready)
      held_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      count_q <= dec_count;
      lo_q    <= dec_lo;
      hi_q    <= dec_hi;
      hitmp_q <= dec_hitmp;
      data_q  <= cmd_data;
    end
  end

  assign step.step_valid = held_q;
  assign step.count_en   = count_q;
  assign step.load_lo    = lo_q;
  assign step.load_hi    = hi_q;
  assign step.hitmp_en   = hitmp_q;
  assign step.step_data  = data_q;

endmodule : pc_cmd_intake

`default_nettype wire

// ==== rtl/pc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// holding byte plus two cascaded 8 bit counters
module pc_core (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     full,       // fetch queue has no room
  pc_step_if.core                 step,
  output logic                    push,
  output pc_types_pkg::pc_addr_t  push_addr   // address after this step
);
  import pc_types_pkg::*;

  pc_byte_t hitmp_q;   // hi byte waiting for a jump
  pc_byte_t lo_q;
  pc_byte_t hi_q;
  pc_byte_t lo_next;
  pc_byte_t hi_next;
  logic     lo_tc;     // lo at terminal count
  logic     fire;      // step applied this edge

  assign step.step_ready = !full;
  assign fire            = step.step_valid && step.step_ready;

  // carry chain like two '163s with TC into the upper CET
  assign lo_tc = (lo_q == PC_BYTE_TC);

  always_comb
  begin
    lo_next = lo_q;
    hi_next = hi_q;
    if (step.load_lo)
      lo_next = step.step_data;         // parallel load beats count
    else if (step.count_en)
      lo_next = lo_q + 8'd1;
    if (step.load_hi)
      hi_next = hitmp_q;                // old holding byte, not this step's data
    else if (step.count_en && lo_tc)
      hi_next = hi_q + 8'd1;            // ripple at 0xff
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lo_q    <= '0;
      hi_q    <= '0;
      hitmp_q <= '0;
    end
    else if (fire)
    begin
      lo_q <= lo_next;
      hi_q <= hi_next;
      if (step.hitmp_en)
        hitmp_q <= step.step_data;
    end
  end

  // queue captures the new value on the same edge as the counters
  assign push      = fire;
  assign push_addr = {hi_next, lo_next};

endmodule : pc_core

`default_nettype wire

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

// circular buffer of fetch addresses, valid/ready on the read side
module fetch_queue #(
  parameter int unsigned DEPTH = pc_ctrl_pkg::FETCH_DEPTH_DEFAULT
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         push,
  input  wire pc_types_pkg::pc_addr_t push_addr,
  output logic                        full,
  output logic                        fetch_valid,
  input  wire                         fetch_ready,
  output pc_types_pkg::pc_addr_t      fetch_addr
);
  import pc_types_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  pc_addr_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held
  logic             wr_en;
  logic             rd_en;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(DEPTH));  // registered, pop not folded in
  assign fetch_valid = (count != '0);
  assign fetch_addr  = mem[rd_ptr];

  assign rd_en = fetch_valid && fetch_ready;
  assign wr_en = push && (!full || rd_en);        // pop frees the slot in time

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_addr;
  end

endmodule : fetch_queue

`default_nettype wire

// ==== rtl/pc_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// pc subsystem, sequencer commands in, fetch addresses out
module pc_fetch_top #(
  parameter int unsigned FETCH_DEPTH = pc_ctrl_pkg::FETCH_DEPTH_DEFAULT
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         cmd_valid,
  output wire                         cmd_ready,
  input  wire pc_ctrl_pkg::pc_op_t    cmd_op,
  input  wire pc_types_pkg::pc_byte_t cmd_data,
  output wire                         fetch_valid,
  input  wire                         fetch_ready,
  output wire pc_types_pkg::pc_addr_t fetch_addr
);
  import pc_types_pkg::*;

  pc_step_if step_bus ();   // decoded command, intake to core

  logic     push;           // core has a new address
  pc_addr_t push_addr;
  logic     full;           // back-pressure into the core

  pc_cmd_intake u_intake (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_data  (cmd_data),
    .step      (step_bus.intake)
  );

  pc_core u_core (
    .clk       (clk),
    .reset     (reset),
    .full      (full),
    .step      (step_bus.core),
    .push      (push),
    .push_addr (push_addr)
  );

  fetch_queue #(
    .DEPTH (FETCH_DEPTH)
  ) u_queue (
    .clk         (clk),
    .reset       (reset),
    .push        (push),
    .push_addr   (push_addr),
    .full        (full),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_addr  (fetch_addr)
  );

endmodule : pc_fetch_top

`default_nettype wire

// ==== test/pc_fetch_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// handshake and reset rules at the pc_fetch_top boundary
module pc_fetch_properties (
  input wire        clk,
  input wire        reset,
  input wire        cmd_valid,
  input wire        cmd_ready,
  input wire [2:0]  cmd_op,
  input wire [7:0]  cmd_data,
  input wire        push,        // core to queue, internal
  input wire        fetch_valid,
  input wire        fetch_ready,
  input wire [15:0] fetch_addr
);
  int unsigned assert_fails = 0;  // summed into the testbench error count

  // stalled command must not move
  cmd_hold: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_data))
    else
    begin
      $error("command changed while cmd_ready was low");
      assert_fails++;
    end

  fetch_hold: assert property (@(posedge clk) disable iff (reset)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr))  // queue head stays
    else
    begin
      $error("fetch output changed while fetch_ready was low");
      assert_fails++;
    end

  // nothing leaves or enters the queue right after reset
  reset_quiet: assert property (@(posedge clk) reset |=> !fetch_valid && !push)
    else
    begin
      $error("fetch_valid or push high in the cycle after reset");
      assert_fails++;
    end

endmodule : pc_fetch_properties

bind pc_fetch_top pc_fetch_properties u_props (
  .clk         (clk),
  .reset       (reset),
  .cmd_valid   (cmd_valid),
  .cmd_ready   (cmd_ready),
  .cmd_op      (cmd_op),
  .cmd_data    (cmd_data),
  .push        (push),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .fetch_addr  (fetch_addr)
);

`default_nettype wire

// ==== test/tb_pc_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

// file driven commands, reference pc model, in-order fetch address checks
module tb_pc_fetch;
  import pc_ctrl_pkg::*;

  logic        clk;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  pc_op_t      cmd_op;
  logic [7:0]  cmd_data;
  logic        fetch_valid;
  logic        fetch_ready;
  logic [15:0] fetch_addr;

  logic [7:0]  cmd_group[$];   // test group of each command
  logic [2:0]  cmd_code[$];
  logic [7:0]  cmd_byte[$];
  logic [15:0] model_addr[$];  // model pc after each command
  logic [15:0] exp_q[$];       // accepted, not fetched yet
  logic [31:0] lfsr_state;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 0;

  pc_fetch_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_op      (cmd_op),
    .cmd_data    (cmd_data),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_addr  (fetch_addr)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  // galois lfsr x^32+x^22+x^2+x+1, one step per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
      lfsr_state = lfsr_state ^ 32'h80200003;
    return b;
  endfunction

  function automatic string group_name(input int g);
    case (g)
      1:       return "reset state";
      2:       return "count with carry";
      3:       return "low load";
      4:       return "holding register and jump";
      default: return "back-pressure";
    endcase
  endfunction

  function automatic logic in_group(input int i, input int g);
    return (i < cmd_code.size()) && (cmd_group[i] == g);
  endfunction

  // sequencer command rules on a plain 16 bit counter
  task automatic apply_rule(input logic [2:0] op, input logic [7:0] data,
                            inout logic [15:0] pc, inout logic [7:0] hitmp);
    case (op)
      op_count:      pc = pc + 16'd1;
      op_load_hitmp:
      begin
        hitmp = data;
        pc    = pc + 16'd1;  // not a lo load, so it counts
      end
      op_load_lo:    pc[7:0] = data;
      op_jump:       pc = {hitmp, data};
      default:       pc = pc;  // hold and unused codes
    endcase
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          lineno;
    string       line;
    logic [7:0]  g;
    logic [7:0]  op;
    logic [7:0]  d;
    logic [15:0] e;
    logic [15:0] pc;
    logic [7:0]  hitmp;
    pc = '0;
    hitmp = '0;
    lineno = 0;
    fd = $fopen("test/pc_fetch_input.txt", "r");
    if (fd == 0)
      $display("cannot open the stimulus file test/pc_fetch_input.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        lineno++;
        if (line.len() >= 2 && line.substr(0, 1) != "//")  // skip comments and blanks
        begin
          n = $sscanf(line, "%h %h %h %h", g, op, d, e);
          if (n == 4)
          begin
            apply_rule(op[2:0], d, pc, hitmp);
            if (pc !== e)
            begin
              errors++;
              $display("stimulus line %0d lists %h but the pc rules give %h", lineno, e, pc);
            end
            cmd_group.push_back(g);
            cmd_code.push_back(op[2:0]);
            cmd_byte.push_back(d);
            model_addr.push_back(pc);
          end
        end
      end
      $fclose(fd);
    end
    limit = 8 * cmd_code.size() + 50;
  endtask

  // offer one group's commands, check every address it produces
  task automatic run_group(input int g);
    int          first_err;
    int          next;
    int          sent;
    int          received;
    logic        offering;
    logic        gap_a;
    logic        gap_b;
    logic [15:0] want;
    first_err = errors;
    next = 0;
    sent = 0;
    received = 0;
    offering = 1'b0;
    if (g == 1)
    begin
      repeat (4)
      begin
        @(negedge clk);
        if (fetch_valid !== 1'b0)
        begin
          errors++;
          $display("FAIL %0t fetch_valid expected 0 got %b", $time, fetch_valid);
        end
        if (cmd_ready !== 1'b1)
        begin
          errors++;
          $display("FAIL %0t cmd_ready expected 1 got %b", $time, cmd_ready);
        end
      end
    end
    while (next < cmd_code.size() && cmd_group[next] != g)
      next++;
    while (in_group(next, g) || offering || exp_q.size() != 0)
    begin
      @(negedge clk);
      if (!offering)
      begin
        cmd_valid = 1'b0;
        gap_a = rand_bit();
        gap_b = rand_bit();
        if (in_group(next, g) && (gap_a || gap_b))  // one cycle in four stays idle
        begin
          cmd_valid = 1'b1;
          cmd_op    = pc_op_t'(cmd_code[next]);
          cmd_data  = cmd_byte[next];
          offering  = 1'b1;
        end
      end
      fetch_ready = (g == 5) ? rand_bit() : 1'b1;
      // outputs are registered, so these decide the next rising edge
      if (fetch_valid && fetch_ready)
      begin
        received++;
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("fetch address %h came out with no command pending", fetch_addr);
        end
        else
        begin
          want = exp_q.pop_front();
          checks++;
          if (fetch_addr !== want)
          begin
            errors++;
            $display("FAIL %0t fetch_addr expected %h got %h", $time, want, fetch_addr);
          end
        end
      end
      if (offering && cmd_ready)
      begin
        exp_q.push_back(model_addr[next]);
        next++;
        sent++;
        offering = 1'b0;
      end
    end
    repeat (2)
    begin
      @(negedge clk);
      cmd_valid = 1'b0;
      fetch_ready = 1'b1;
      if (fetch_valid)
      begin
        errors++;
        $display("extra fetch address %h after group %0d drained", fetch_addr, g);
      end
    end
    if (received != sent)
    begin
      errors++;
      $display("group %0d sent %0d commands but received %0d addresses", g, sent, received);
    end
    $display("group %0d %s: %0d commands, %0d addresses, %s", g, group_name(g), sent,
             received, (errors == first_err) ? "pass" : "fail");
  endtask

  initial
  begin
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = op_hold;
    cmd_data = '0;
    fetch_ready = 1'b0;
    lfsr_state = 32'd79815;
    load_stimulus();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (cmd_code.size() == 0)
    begin
      errors++;
      $display("no commands were read from the stimulus file");
    end
    else
    begin
      for (int g = 1; g <= 5; g++)
        run_group(g);
    end
    if (u_dut.u_props.assert_fails != 0)
    begin
      errors += u_dut.u_props.assert_fails;
      $display("%0d bound assertion failures", u_dut.u_props.assert_fails);
    end
    $display("commands %0d, address checks %0d, errors %0d", cmd_code.size(), checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // limit follows the stimulus length
  initial
  begin
    wait (limit != 0);
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles with %0d addresses still due", cycles,
             exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_pc_fetch

`default_nettype wire

// ==== cpu_pc.f ====
rtl/pc_types_pkg.sv
rtl/pc_ctrl_pkg.sv
rtl/pc_step_if.sv
rtl/pc_cmd_intake.sv
rtl/pc_core.sv
rtl/fetch_queue.sv
rtl/pc_fetch_top.sv
test/pc_fetch_properties.sv
test/tb_pc_fetch.sv

// ==== Bender.yml ====
package:
  name: cpu_pc

sources:
  - files:
      - rtl/pc_types_pkg.sv
      - rtl/pc_ctrl_pkg.sv
      - rtl/pc_step_if.sv
      - rtl/pc_cmd_intake.sv
      - rtl/pc_core.sv
      - rtl/fetch_queue.sv
      - rtl/pc_fetch_top.sv
  - target: test
    files:
      - test/pc_fetch_properties.sv
      - test/tb_pc_fetch.sv

// ==== test/pc_fetch_input.txt ====
// group op data expected_addr, all hex; op 0 hold 1 count 2 load_hitmp 3 load_lo 4 jump
// groups: 1 reset state, 2 carry, 3 low load, 4 holding register and jump, 5 back-pressure
1 1 00 0001
1 0 00 0001
2 3 fe 00fe
2 1 00 00ff
2 1 00 0100
2 1 00 0101
3 3 34 0134
3 1 00 0135
3 3 00 0100
4 2 12 0101
4 4 78 1278
4 0 00 1278
4 2 ab 1279
4 4 cd abcd
4 7 55 abcd
5 1 00 abce
5 3 fe abfe
5 1 00 abff
5 1 00 ac00
5 2 ff ac01
5 4 00 ff00
5 3 ff ffff
5 1 00 0000
5 0 00 0000
